// File: hdl/fp_wb_defs.svh
/*
 * Writeback stage constants.
 * Unit count, binary32 field widths and control register addresses.
 */

`ifndef FP_WB_DEFS_SVH
`define FP_WB_DEFS_SVH

// unit request ports on the arbiter
`define FP_NUM_UNITS 4

// binary32 field widths
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23

// control block register map, 1-bit address
`define FP_CSR_FRM    1'b0
`define FP_CSR_FFLAGS 1'b1

`endif

// File: hdl/fp_format_pkg.sv
/*
 * Floating-point format types.
 * Binary32 field layout, the two-view word union, rounding modes,
 * guard/round/sticky bits and the IEEE-754 exception flags.
 */

`include "fp_wb_defs.svh"

package fp_format_pkg;

    typedef struct packed {
        logic                      sign;
        logic [`FP_EXPO_WIDTH-1:0] expo;
        logic [`FP_FRAC_WIDTH-1:0] frac;
    } fp32_fields_t;

    // raw view for moving, field view for decoding
    typedef union packed {
        logic [`FP_EXPO_WIDTH+`FP_FRAC_WIDTH:0] raw;
        fp32_fields_t                           f;
    } fp32_word_u;

    // encodings follow the RISC-V frm field
    typedef enum logic [2:0] {
        rne = 3'b000,
        rtz = 3'b001,
        rdn = 3'b010,
        rup = 3'b011,
        rmm = 3'b100,
        dyn = 3'b111
    } rounding_mode_t;

    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } grs_t;

    // msb first, same order as fcsr.fflags
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

endpackage

// File: hdl/fp_wb_pkg.sv
/*
 * Writeback stage packets.
 * Unit offers, the normalize and round pipeline packets, the result
 * port and the host control port.
 */

`include "fp_wb_defs.svh"

package fp_wb_pkg;
    import fp_format_pkg::*;

    // one unit's unrounded result
    typedef struct packed {
        logic [3:0]     id;
        fp32_word_u     data;
        logic           expo_overflow;
        logic           hidden;
        logic           carry;
        logic [4:0]     clz;
        grs_t           grs;
        fflags_t        fflags;
        rounding_mode_t rm;
    } fp_unit_result_t;

    typedef struct packed {
        logic            valid;
        fp_unit_result_t result;
    } fp_norm_packet_t;

    // normalized value plus the precomputed rounding decision
    typedef struct packed {
        logic           valid;
        logic [3:0]     id;
        fp32_word_u     data;
        logic           hidden;
        logic           expo_overflow;
        logic           roundup;
        fp32_word_u     overflow_word;
        fflags_t        fflags;
        rounding_mode_t rm;
    } fp_round_packet_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] id;
        fp32_word_u data;
    } fp_wb_packet_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] id;
        fflags_t    fflags;
    } fp_fflags_wb_t;

    // host port, four-phase req/ack
    typedef struct packed {
        logic       req;
        logic       write;
        logic       addr;
        logic [4:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic       ack;
        logic [4:0] rdata;
    } csr_rsp_t;

endpackage

// File: hdl/fp_wb_arbiter.sv
/*
 * Writeback arbiter.
 * Picks the lowest-numbered unit with done high each cycle, acks it
 * combinationally and forwards its result to the normalizer.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_wb_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`FP_NUM_UNITS-1:0]   done,
    input  fp_wb_pkg::fp_unit_result_t unit_result [`FP_NUM_UNITS],
    output logic [`FP_NUM_UNITS-1:0]   ack,
    output fp_wb_pkg::fp_norm_packet_t sel_packet
);

    localparam int SEL_W = $clog2(`FP_NUM_UNITS);

    logic [SEL_W-1:0] sel;
    logic             any_done;

    // priority encoder, last hit from the top wins so index 0 is highest
    always_comb begin
        sel = '0;
        for (int i = `FP_NUM_UNITS - 1; i >= 0; i--) begin
            if (done[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign any_done = |done;

    always_comb begin
        ack      = '0;
        ack[sel] = any_done;
    end

    assign sel_packet.valid  = any_done;
    assign sel_packet.result = unit_result[sel];

    //////////////////////////////////////////////////////////////////////
    // assertions

    a_ack_onehot : assert property (
        @(posedge clk) disable iff (rst) $onehot0(ack)
    );

    // units see ack only while offering
    a_ack_done : assert property (
        @(posedge clk) disable iff (rst) (ack & ~done) == '0
    );

endmodule

// File: hdl/fp_normalize.sv
/*
 * Shared normalizer.
 * Registers the selected result, normalizes it by one right shift or a
 * leading-zero left shift, and precomputes roundup and the overflow word.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_normalize (
    input  logic                          clk,
    input  logic                          rst,
    input  fp_wb_pkg::fp_norm_packet_t    sel_packet,
    input  fp_format_pkg::rounding_mode_t frm,
    output fp_wb_pkg::fp_round_packet_t   norm_packet
);
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    localparam int EW = `FP_EXPO_WIDTH;
    localparam int FW = `FP_FRAC_WIDTH;

    logic             in_valid_r;
    fp_unit_result_t  in_r;
    fp32_fields_t     f_in;
    logic [FW+3:0]    left_vec;
    logic [EW-1:0]    expo_n;
    logic             expo_ovf_n;
    logic [FW-1:0]    frac_n;
    logic             hidden_n;
    grs_t             grs_n;
    rounding_mode_t   rm_eff;
    logic             inexact;
    logic             roundup;
    logic             use_max;
    fp32_word_u       ovf_word;
    fp_round_packet_t out_c;
    logic             out_valid_r;
    fp_round_packet_t out_r;

    //////////////////////////////////////////////////////////////////////
    // input register

    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid_r <= 1'b0;
        end else begin
            in_valid_r <= sel_packet.valid;
        end
    end

    always_ff @(posedge clk) begin
        in_r <= sel_packet.result;
    end

    //////////////////////////////////////////////////////////////////////
    // normalize

    assign f_in     = in_r.data.f;
    assign left_vec = {in_r.hidden, f_in.frac, in_r.grs} << in_r.clz;

    always_comb begin
        if (in_r.carry) begin
            // carry becomes the hidden bit, lost lsb goes to guard
            hidden_n     = in_r.carry;
            frac_n       = {in_r.hidden, f_in.frac[FW-1:1]};
            grs_n.guard  = f_in.frac[0];
            grs_n.round  = in_r.grs.guard;
            grs_n.sticky = in_r.grs.round | in_r.grs.sticky;
            expo_n       = f_in.expo + EW'(1);
            expo_ovf_n   = in_r.expo_overflow | (&f_in.expo);
        end else begin
            hidden_n     = left_vec[FW+3];
            frac_n       = left_vec[FW+2:3];
            grs_n        = left_vec[2:0];
            expo_n       = f_in.expo - EW'(in_r.clz);
            expo_ovf_n   = in_r.expo_overflow;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // rounding decision

    assign rm_eff  = (in_r.rm == dyn) ? frm : in_r.rm;
    assign inexact = |grs_n;

    always_comb begin
        case (rm_eff)
            rne:     roundup = grs_n.guard & (grs_n.round | grs_n.sticky | frac_n[0]);
            rdn:     roundup = f_in.sign & inexact;
            rup:     roundup = ~f_in.sign & inexact;
            rmm:     roundup = grs_n.guard;
            default: roundup = 1'b0;
        endcase
    end

    // largest finite value when the mode rounds toward zero for this sign
    assign use_max = (rm_eff == rtz) | ((rm_eff == rdn) & ~f_in.sign) |
                     ((rm_eff == rup) & f_in.sign);

    always_comb begin
        ovf_word.f.sign = f_in.sign;
        ovf_word.f.expo = use_max ? ~EW'(1) : '1;
        ovf_word.f.frac = use_max ? '1 : '0;
    end

    always_comb begin
        out_c.valid         = in_valid_r;
        out_c.id            = in_r.id;
        out_c.rm            = rm_eff;
        out_c.overflow_word = ovf_word;
        if (in_r.fflags.nv) begin
            // invalid results go out as the unit made them
            out_c.data          = in_r.data;
            out_c.hidden        = in_r.hidden;
            out_c.expo_overflow = 1'b0;
            out_c.roundup       = 1'b0;
            out_c.fflags        = in_r.fflags;
        end else begin
            out_c.data.f.sign   = f_in.sign;
            out_c.data.f.expo   = expo_n;
            out_c.data.f.frac   = frac_n;
            out_c.hidden        = hidden_n;
            out_c.expo_overflow = expo_ovf_n;
            out_c.roundup       = roundup;
            out_c.fflags        = in_r.fflags;
            out_c.fflags.nx     = in_r.fflags.nx | inexact;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_r <= 1'b0;
        end else begin
            out_valid_r <= out_c.valid;
        end
    end

    always_ff @(posedge clk) begin
        out_r <= out_c;
    end

    always_comb begin
        norm_packet       = out_r;
        norm_packet.valid = out_valid_r;
    end

    // units keep the left shift inside the normal range
    a_clz_range : assert property (
        @(posedge clk) disable iff (rst)
        (in_valid_r && !in_r.carry && !in_r.fflags.nv) |-> (EW'(in_r.clz) < f_in.expo)
    );

endmodule

// File: hdl/fp_round.sv
/*
 * Shared rounder.
 * Applies roundup to the normalized fraction, handles the fraction
 * carry and exponent overflow, and registers the writeback and flags.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_round (
    input  logic                        clk,
    input  logic                        rst,
    input  fp_wb_pkg::fp_round_packet_t norm_packet,
    output fp_wb_pkg::fp_wb_packet_t    wb,
    output fp_wb_pkg::fp_fflags_wb_t    fflags_wb
);
    import fp_format_pkg::*;

    localparam int EW = `FP_EXPO_WIDTH;
    localparam int FW = `FP_FRAC_WIDTH;

    fp32_fields_t  f;
    logic [FW+1:0] sum;
    logic          frac_carry;
    logic          frac_ovf;
    logic [FW-1:0] frac_out;
    logic          expo_carry;
    logic [EW-1:0] expo_out;
    logic          overflow;
    fp32_word_u    data_c;
    fflags_t       flags_c;
    logic          valid_r;
    logic [3:0]    id_r;
    fp32_word_u    data_r;
    fflags_t       flags_r;

    assign f = norm_packet.data.f;

    // the adder carry, used only to cross-check the fast detect
    assign sum        = {1'b0, norm_packet.hidden, f.frac} + (FW+2)'(norm_packet.roundup);
    assign frac_carry = sum[FW+1];

    // all ones plus one, known without waiting on the adder
    assign frac_ovf = &{norm_packet.hidden, f.frac, norm_packet.roundup};

    assign frac_out = frac_ovf ? sum[FW:1] : sum[FW-1:0];

    assign {expo_carry, expo_out} = {1'b0, f.expo} + (EW+1)'(frac_ovf);

    // 255 is reserved for inf/nan
    assign overflow = expo_carry | norm_packet.expo_overflow | (&expo_out);

    always_comb begin
        if (norm_packet.fflags.nv) begin
            data_c  = norm_packet.data;
            flags_c = norm_packet.fflags;
        end else if (overflow) begin
            data_c     = norm_packet.overflow_word;
            flags_c    = norm_packet.fflags;
            flags_c.of = 1'b1;
            flags_c.nx = 1'b1;
        end else begin
            data_c.f.sign = f.sign;
            data_c.f.expo = expo_out;
            data_c.f.frac = frac_out;
            flags_c       = norm_packet.fflags;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= norm_packet.valid;
        end
    end

    always_ff @(posedge clk) begin
        id_r    <= norm_packet.id;
        data_r  <= data_c;
        flags_r <= flags_c;
    end

    assign wb.valid         = valid_r;
    assign wb.id            = id_r;
    assign wb.data          = data_r;
    assign fflags_wb.valid  = valid_r;
    assign fflags_wb.id     = id_r;
    assign fflags_wb.fflags = flags_r;

    //////////////////////////////////////////////////////////////////////
    // assertions

    a_frac_ovf : assert property (
        @(posedge clk) disable iff (rst) norm_packet.valid |-> (frac_ovf == frac_carry)
    );

    // dyn must be resolved upstream against the control block
    a_rm_resolved : assert property (
        @(posedge clk) disable iff (rst) norm_packet.valid |-> (norm_packet.rm != dyn)
    );

endmodule

// File: hdl/fp_wb_csr.sv
/*
 * Rounding and flag control block.
 * Holds the dynamic rounding mode and sticky exception flags behind a
 * four-phase req/ack host port.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_wb_csr (
    input  logic                          clk,
    input  logic                          rst,
    input  fp_wb_pkg::csr_req_t           csr_req,
    output fp_wb_pkg::csr_rsp_t           csr_rsp,
    input  fp_wb_pkg::fp_fflags_wb_t      fflags_wb,
    output fp_format_pkg::rounding_mode_t frm
);
    import fp_format_pkg::*;

    logic           ack_r;
    logic [4:0]     rdata_r;
    rounding_mode_t frm_r;
    fflags_t        flags_r;
    fflags_t        wb_flags;
    logic           access;
    logic           frm_code_ok;
    logic           frm_write;
    logic           flags_write;

    // one access per request, on the edge before ack rises
    assign access      = csr_req.req & ~ack_r;
    assign frm_code_ok = csr_req.wdata <= 5'(rmm);
    assign frm_write   = access & csr_req.write & (csr_req.addr == `FP_CSR_FRM) & frm_code_ok;
    assign flags_write = access & csr_req.write & (csr_req.addr == `FP_CSR_FFLAGS);

    assign wb_flags = fflags_wb.valid ? fflags_wb.fflags : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_r   <= 1'b0;
            frm_r   <= rne;
            flags_r <= '0;
        end else begin
            // ack follows req by one cycle in both directions
            ack_r <= csr_req.req;
            if (frm_write) begin
                frm_r <= rounding_mode_t'(csr_req.wdata[2:0]);
            end
            if (flags_write) begin
                flags_r <= fflags_t'(csr_req.wdata) | wb_flags;
            end else begin
                flags_r <= flags_r | wb_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_r <= (csr_req.addr == `FP_CSR_FFLAGS) ? flags_r : {2'b00, frm_r};
        end
    end

    assign csr_rsp.ack   = ack_r;
    assign csr_rsp.rdata = rdata_r;
    assign frm           = frm_r;

    a_ack_after_req : assert property (
        @(posedge clk) disable iff (rst) $rose(ack_r) |-> $past(csr_req.req)
    );

endmodule

// File: hdl/fp_writeback.sv
/*
 * Floating-point writeback stage.
 * Arbitrates unit results, then normalizes and rounds them into
 * binary32 writebacks with flags; frm and sticky flags sit alongside.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_writeback (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`FP_NUM_UNITS-1:0]   done,
    input  fp_wb_pkg::fp_unit_result_t unit_result [`FP_NUM_UNITS],
    output logic [`FP_NUM_UNITS-1:0]   ack,
    output fp_wb_pkg::fp_wb_packet_t   wb,
    output fp_wb_pkg::fp_fflags_wb_t   fflags_wb,
    input  fp_wb_pkg::csr_req_t        csr_req,
    output fp_wb_pkg::csr_rsp_t        csr_rsp
);
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    fp_norm_packet_t  sel_packet;
    fp_round_packet_t norm_packet;
    rounding_mode_t   frm;

    // select, zero cycles
    fp_wb_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .done        (done),
        .unit_result (unit_result),
        .ack         (ack),
        .sel_packet  (sel_packet)
    );

    // normalize, one cycle after capture
    fp_normalize u_normalize (
        .clk         (clk),
        .rst         (rst),
        .sel_packet  (sel_packet),
        .frm         (frm),
        .norm_packet (norm_packet)
    );

    // round, one cycle
    fp_round u_round (
        .clk         (clk),
        .rst         (rst),
        .norm_packet (norm_packet),
        .wb          (wb),
        .fflags_wb   (fflags_wb)
    );

    fp_wb_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp),
        .fflags_wb (fflags_wb),
        .frm       (frm)
    );

endmodule

// File: sim/fp_writeback_tb.sv
/*
 * Testbench for the floating-point writeback stage.
 * Drives unit offers and host accesses, predicts every writeback with
 * a reference model, and checks data, flags, timing and sticky flags.
 */

`timescale 1ns/1ps
`include "fp_wb_defs.svh"

module fp_writeback_tb;
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_UNITS    = `FP_NUM_UNITS;
    localparam int PER_CASE   = 8;
    // single unit plus all units twice plus overflow, nv and dyn rounding
    localparam int NUM_RESULTS    = 5 * 2 * PER_CASE + 2 * N_UNITS + 5 * 2 * 3 + 4 + 5 * 4;
    localparam int TIMEOUT_CYCLES = NUM_RESULTS * 20 + 500;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        fflags_t     flags;
    } expect_t;

    logic            clk = 1'b0;
    logic            rst;
    logic [N_UNITS-1:0] done;
    fp_unit_result_t unit_result [N_UNITS];
    logic [N_UNITS-1:0] ack;
    fp_wb_packet_t   wb;
    fp_fflags_wb_t   fflags_wb;
    csr_req_t        csr_req;
    csr_rsp_t        csr_rsp;

    rounding_mode_t  frm_model;
    fflags_t         sticky_model;
    expect_t         exp_q [$];
    int              edge_q [$];
    int              ack_log [$];
    int              ack_count [N_UNITS];
    int              cycle = 0;
    int              errors = 0;
    int              compared = 0;
    int              reads = 0;
    rounding_mode_t  modes [5] = '{rne, rtz, rdn, rup, rmm};

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    fp_writeback uut (
        .clk         (clk),
        .rst         (rst),
        .done        (done),
        .unit_result (unit_result),
        .ack         (ack),
        .wb          (wb),
        .fflags_wb   (fflags_wb),
        .csr_req     (csr_req),
        .csr_rsp     (csr_rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic expect_t predict_result(input fp_unit_result_t r,
                                               input rounding_mode_t frm_now);
        expect_t        e;
        rounding_mode_t mode;
        logic [27:0]    wide;
        logic [26:0]    sig;
        logic [23:0]    mant;
        logic [24:0]    rounded;
        logic           g;
        logic           rb;
        logic           st;
        logic           inexact;
        logic           up;
        logic           sign;
        logic           big;
        int             exp_v;

        e.id    = r.id;
        e.data  = r.data.raw;
        e.flags = r.fflags;
        // invalid results are written back as delivered
        if (r.fflags.nv) begin
            return e;
        end
        mode  = (r.rm == dyn) ? frm_now : r.rm;
        sign  = r.data.f.sign;
        exp_v = int'(r.data.f.expo);
        if (r.carry) begin
            // one place right with the dropped bits folded into sticky
            wide  = {r.carry, r.hidden, r.data.f.frac, r.grs};
            mant  = wide[27:4];
            g     = wide[3];
            rb    = wide[2];
            st    = |wide[1:0];
            exp_v = exp_v + 1;
        end else begin
            sig   = {r.hidden, r.data.f.frac, r.grs};
            sig   = sig << r.clz;
            mant  = sig[26:3];
            g     = sig[2];
            rb    = sig[1];
            st    = sig[0];
            exp_v = exp_v - int'(r.clz);
        end
        inexact = g | rb | st;
        case (mode)
            rne:     up = g & (rb | st | mant[0]);
            rdn:     up = sign & inexact;
            rup:     up = ~sign & inexact;
            rmm:     up = g;
            default: up = 1'b0;
        endcase
        rounded = {1'b0, mant} + {24'd0, up};
        if (rounded[24]) begin
            rounded = rounded >> 1;
            exp_v   = exp_v + 1;
        end
        if (inexact) begin
            e.flags.nx = 1'b1;
        end
        if (r.expo_overflow || exp_v >= 255) begin
            // modes that round toward zero for this sign stop at max finite
            big        = (mode == rtz) || (mode == rdn && !sign) || (mode == rup && sign);
            e.data     = big ? {sign, 8'hfe, 23'h7fffff} : {sign, 8'hff, 23'h000000};
            e.flags.of = 1'b1;
            e.flags.nx = 1'b1;
        end else begin
            e.data = {sign, 8'(exp_v), rounded[22:0]};
        end
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    function automatic fp_unit_result_t make_carry(input logic [3:0] id,
                                                   input rounding_mode_t rm,
                                                   input int expo);
        fp_unit_result_t r;
        r = '0;
        r.id          = id;
        r.data.f.sign = 1'($urandom());
        r.data.f.expo = 8'(expo);
        r.data.f.frac = 23'($urandom());
        r.hidden      = 1'($urandom());
        r.carry       = 1'b1;
        r.grs         = 3'($urandom());
        r.rm          = rm;
        return r;
    endfunction

    // leading one placed so that clz matches the significand
    function automatic fp_unit_result_t make_shift(input logic [3:0] id,
                                                   input rounding_mode_t rm);
        fp_unit_result_t r;
        int              clz;
        int              pos;
        logic [26:0]     sig;
        r   = '0;
        clz = int'($urandom_range(0, 26));
        pos = 26 - clz;
        sig = 27'($urandom()) & ((27'd1 << pos) - 27'd1);
        sig[pos] = 1'b1;
        r.id          = id;
        r.data.f.sign = 1'($urandom());
        r.data.f.expo = 8'($urandom_range(clz + 1, 254));
        {r.hidden, r.data.f.frac, r.grs} = sig;
        r.clz = 5'(clz);
        r.rm  = rm;
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    // starts and ends on a falling edge
    task automatic offer(input int u, input fp_unit_result_t r);
        done[u]        = 1'b1;
        unit_result[u] = r;
        do begin
            @(posedge clk);
        end while (!ack[u]);
        @(negedge clk);
        done[u] = 1'b0;
    endtask

    // four-phase host access
    task automatic csr_access(input logic write, input logic addr,
                              input logic [4:0] wdata, output logic [4:0] rdata);
        csr_req.req   = 1'b1;
        csr_req.write = write;
        csr_req.addr  = addr;
        csr_req.wdata = wdata;
        do begin
            @(negedge clk);
        end while (!csr_rsp.ack);
        rdata       = csr_rsp.rdata;
        csr_req.req = 1'b0;
        do begin
            @(negedge clk);
        end while (csr_rsp.ack);
    endtask

    task automatic read_csr(input logic addr, input logic [4:0] exp, input string name);
        logic [4:0] rd;
        csr_access(1'b0, addr, 5'd0, rd);
        reads++;
        if (rd !== exp) begin
            report_mismatch(name, 32'(rd), 32'(exp));
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // ack monitor and scoreboard

    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < N_UNITS; i++) begin
                if (ack[i]) begin
                    exp_q.push_back(predict_result(unit_result[i], frm_model));
                    edge_q.push_back(cycle + 1);
                    ack_log.push_back(i);
                    ack_count[i]++;
                end
            end
        end
    end

    always @(negedge clk) begin
        expect_t e;
        int      t;
        if (!rst) begin
            if (fflags_wb.valid !== wb.valid) begin
                report_mismatch("fflags_wb.valid", 32'(fflags_wb.valid), 32'(wb.valid));
            end
            if (wb.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR %0t ns: writeback id %h with no result pending",
                             $time, wb.id);
                end else begin
                    e = exp_q.pop_front();
                    t = edge_q.pop_front();
                    compared++;
                    if (wb.id !== e.id) begin
                        report_mismatch("wb.id", 32'(wb.id), 32'(e.id));
                    end
                    if (fflags_wb.id !== e.id) begin
                        report_mismatch("fflags_wb.id", 32'(fflags_wb.id), 32'(e.id));
                    end
                    if (wb.data.raw !== e.data) begin
                        report_mismatch("wb.data", wb.data.raw, e.data);
                    end
                    if (fflags_wb.fflags !== e.flags) begin
                        report_mismatch("fflags_wb.fflags", 32'(fflags_wb.fflags),
                                        32'(e.flags));
                    end
                    if (cycle != t + 2) begin
                        errors++;
                        $display("ERROR %0t ns: id %h came %0d cycles after its ack, not 2",
                                 $time, wb.id, cycle - t);
                    end
                    sticky_model = sticky_model | e.flags;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        logic [4:0]      rd;
        fp_unit_result_t r;
        void'($urandom(41));
        $timeformat(-9, 0, "", 0);
        rst          = 1'b1;
        done         = '0;
        csr_req      = '0;
        frm_model    = rne;
        sticky_model = '0;
        for (int i = 0; i < N_UNITS; i++) begin
            unit_result[i] = '0;
            ack_count[i]   = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        if (wb.valid !== 1'b0) begin
            report_mismatch("wb.valid", 32'(wb.valid), 32'd0);
        end
        if (fflags_wb.valid !== 1'b0) begin
            report_mismatch("fflags_wb.valid", 32'(fflags_wb.valid), 32'd0);
        end
        if (csr_rsp.ack !== 1'b0) begin
            report_mismatch("csr_rsp.ack", 32'(csr_rsp.ack), 32'd0);
        end
        read_csr(`FP_CSR_FFLAGS, 5'd0, "csr_rsp.rdata fflags");

        // single unit back to back in every static mode
        foreach (modes[m]) begin
            for (int k = 0; k < PER_CASE; k++) begin
                offer(0, make_carry(4'(k), modes[m], int'($urandom_range(1, 253))));
                offer(0, make_shift(4'(k + 8), modes[m]));
            end
        end
        drain();

        // all units at once so the lowest index wins
        repeat (2) begin
            ack_log.delete();
            for (int i = 0; i < N_UNITS; i++) begin
                ack_count[i] = 0;
            end
            fork
                offer(0, make_shift(4'd0, rne));
                offer(1, make_carry(4'd1, rup, 100));
                offer(2, make_shift(4'd2, rdn));
                offer(3, make_carry(4'd3, rmm, 200));
            join
            for (int i = 0; i < N_UNITS; i++) begin
                if (ack_count[i] != 1) begin
                    errors++;
                    $display("ERROR %0t ns: unit %0d acked %0d times", $time, i, ack_count[i]);
                end
            end
            for (int k = 0; k < ack_log.size(); k++) begin
                if (ack_log[k] != k) begin
                    report_mismatch("ack order", 32'(ack_log[k]), 32'(k));
                end
            end
        end
        drain();

        // overflow by exponent, unit flag and rounding before the nv pass through
        foreach (modes[m]) begin
            for (int s = 0; s < 2; s++) begin
                r = make_carry(4'd1, modes[m], 254);
                r.data.f.sign = 1'(s);
                offer(0, r);
                r = make_shift(4'd2, modes[m]);
                r.data.f.sign   = 1'(s);
                r.expo_overflow = 1'b1;
                offer(1, r);
                r = '0;
                r.id          = 4'd3;
                r.data.f.sign = 1'(s);
                r.data.f.expo = 8'd254;
                r.data.f.frac = '1;
                r.hidden      = 1'b1;
                r.grs         = 3'b111;
                r.rm          = modes[m];
                offer(2, r);
            end
        end
        for (int k = 0; k < 4; k++) begin
            r = make_shift(4'(k), modes[k]);
            r.data.raw  = $urandom();
            r.fflags.nv = 1'b1;
            r.fflags.nx = 1'($urandom());
            offer(3, r);
        end
        drain();

        // dynamic mode from the control block
        foreach (modes[m]) begin
            csr_access(1'b1, `FP_CSR_FRM, 5'(modes[m]), rd);
            frm_model = modes[m];
            read_csr(`FP_CSR_FRM, 5'(modes[m]), "csr_rsp.rdata frm");
            for (int k = 0; k < 2; k++) begin
                offer(k, make_carry(4'(m), dyn, int'($urandom_range(1, 253))));
                offer(k + 2, make_shift(4'(m + 8), dyn));
            end
            drain();
        end
        // dyn is not a legal frm value
        csr_access(1'b1, `FP_CSR_FRM, 5'd7, rd);
        read_csr(`FP_CSR_FRM, 5'(rmm), "csr_rsp.rdata frm");

        read_csr(`FP_CSR_FFLAGS, 5'(sticky_model), "csr_rsp.rdata fflags");
        csr_access(1'b1, `FP_CSR_FFLAGS, 5'd0, rd);
        sticky_model = '0;
        read_csr(`FP_CSR_FFLAGS, 5'd0, "csr_rsp.rdata fflags");
        drain();

        if (compared != NUM_RESULTS) begin
            errors++;
            $display("ERROR %0t ns: %0d writebacks seen, %0d expected",
                     $time, compared, NUM_RESULTS);
        end
        $display("writebacks checked %0d, host reads %0d, errors %0d",
                 compared, reads, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/fp_format_pkg.sv
hdl/fp_wb_pkg.sv
hdl/fp_wb_arbiter.sv
hdl/fp_normalize.sv
hdl/fp_round.sv
hdl/fp_wb_csr.sv
hdl/fp_writeback.sv
sim/fp_writeback_tb.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := fp_writeback_tb
FLIST := flist.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
